//--- flist.f
+incdir+.
burst_split_pkg.sv
beat_count_if.sv
ar_split_fsm.sv
beat_count_table.sv
r_last_rebuild.sv
burst_split_top.sv
burst_split_assert.sv
tb_burst_split.sv

//--- tb_burst_split.sv
// Testbench for the burst splitter driving random AR bursts against a downstream memory model
`default_nettype none

module tb_burst_split
  import burst_split_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int PHASES         = 4;
  // Upstream bursts per limit phase
  localparam int BURSTS         = 12;
  localparam int TIMEOUT_CYCLES = 40 * PHASES * BURSTS;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    id_t    id;
  } ar_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
    id_t   id;
    logic  last;
  } r_beat_t;

  logic   clk_i;
  logic   rst_n_i;
  len_t   len_limit_i;
  logic   s_ar_valid_i;
  logic   s_ar_ready_o;
  addr_t  s_ar_addr_i;
  len_t   s_ar_len_i;
  size_t  s_ar_size_i;
  burst_t s_ar_burst_i;
  id_t    s_ar_id_i;
  logic   s_r_valid_o;
  logic   s_r_ready_i;
  data_t  s_r_data_o;
  resp_t  s_r_resp_o;
  id_t    s_r_id_o;
  logic   s_r_last_o;
  logic   m_ar_valid_o;
  logic   m_ar_ready_i;
  addr_t  m_ar_addr_o;
  len_t   m_ar_len_o;
  size_t  m_ar_size_o;
  burst_t m_ar_burst_o;
  id_t    m_ar_id_o;
  logic   m_r_valid_i;
  logic   m_r_ready_o;
  data_t  m_r_data_i;
  resp_t  m_r_resp_i;
  id_t    m_r_id_i;
  logic   m_r_last_i;

  // Expected downstream ARs and upstream R beats, in order
  ar_t         exp_ar[$];
  r_beat_t     exp_r[$];
  // ARs accepted by the memory model, oldest first
  ar_t         mem_ar[$];
  int unsigned mismatch_count = 0;
  int unsigned other_count    = 0;
  int unsigned cycle_count    = 0;
  logic [15:0] lfsr_q         = 16'd60454;

  burst_split_top u_dut (.*);

  bind burst_split_top burst_split_assert u_assert (.*);

  // ----------------------------------------------------------------------
  // Random bits from a 16-bit Fibonacci LFSR with taps 16 14 13 11
  // ----------------------------------------------------------------------
  function automatic logic take_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
      v = (v << 1) | int'(take_bit());
    end
    return v;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // Sub-burst ARs and upstream R beats of one upstream burst
  function automatic void build_expected(input ar_t up, input len_t limit);
    int unsigned total;
    int unsigned step;
    int unsigned sent;
    int unsigned chunk;
    int unsigned i;
    ar_t         sub;
    r_beat_t     beat;
    total = int'(up.len) + 1;
    step  = int'(limit) + 1;
    sent  = 0;
    while (sent < total) begin
      chunk   = (total - sent > step) ? step : total - sent;
      sub     = up;
      sub.len = len_t'(chunk - 1);
      // FIXED keeps the start address
      if (up.burst == BURST_INCR) begin
        sub.addr = up.addr + (addr_t'(sent) << up.size);
      end
      exp_ar.push_back(sub);
      sent += chunk;
    end
    // Each beat carries its own address as data
    for (i = 0; i < total; i++) begin
      beat.data = (up.burst == BURST_INCR) ? up.addr + (addr_t'(i) << up.size) : up.addr;
      // Memory model takes the response code from the beat address
      beat.resp = resp_t'(beat.data >> 2);
      beat.id   = up.id;
      beat.last = (i == total - 1);
      exp_r.push_back(beat);
    end
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      mismatch_count++;
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = u_dut.u_assert.fail_count;
    $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_count, other_count, assert_fails);
    if (mismatch_count == 0 && other_count == 0 && assert_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  // Hold one upstream AR until the DUT takes it
  task automatic send_burst(input ar_t up);
    s_ar_valid_i = 1'b1;
    s_ar_addr_i  = up.addr;
    s_ar_len_i   = up.len;
    s_ar_size_i  = up.size;
    s_ar_burst_i = up.burst;
    s_ar_id_i    = up.id;
    @(posedge clk_i);
    while (!s_ar_ready_o) begin
      @(posedge clk_i);
    end
    #10;
    s_ar_valid_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Clock, ready gaps and downstream memory model
  // ----------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // About one stall cycle in four on each ready
  initial begin : ready_gaps
    logic ar_rdy;
    logic r_rdy;
    forever begin
      @(posedge clk_i);
      // Drawn on the edge and driven with the other inputs
      ar_rdy = (take_bits(2) != 0);
      r_rdy  = (take_bits(2) != 0);
      #10;
      m_ar_ready_i = ar_rdy;
      s_r_ready_i  = r_rdy;
    end
  end

  initial begin : mem_model
    int unsigned beat;
    ar_t         cur;
    beat = 0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
        mem_ar.push_back({m_ar_addr_o, m_ar_len_o, m_ar_size_o, m_ar_burst_o, m_ar_id_o});
      end
      if (m_r_valid_i && m_r_ready_o) begin
        if (beat == mem_ar[0].len) begin
          void'(mem_ar.pop_front());
          beat = 0;
        end else begin
          beat++;
        end
      end
      #10;
      if (mem_ar.size() != 0) begin
        cur         = mem_ar[0];
        m_r_valid_i = 1'b1;
        m_r_data_i  = (cur.burst == BURST_INCR) ? cur.addr + (addr_t'(beat) << cur.size)
                                                : cur.addr;
        // Response code follows the beat address so beats differ
        m_r_resp_i  = resp_t'(m_r_data_i >> 2);
        m_r_id_i    = cur.id;
        // Last on every sub-burst end
        m_r_last_i  = (beat == cur.len);
      end else begin
        m_r_valid_i = 1'b0;
        m_r_last_i  = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Compare transfers with the reference lists
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    ar_t     exp_a;
    r_beat_t exp_b;
    if (rst_n_i) begin
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (exp_ar.size() == 0) begin
          other_count++;
          $display("ERROR: downstream AR at %0t with no sub-burst expected", $time);
        end else begin
          exp_a = exp_ar.pop_front();
          compare_value("m_ar_addr_o", exp_a.addr, m_ar_addr_o);
          compare_value("m_ar_len_o", exp_a.len, m_ar_len_o);
          compare_value("m_ar_size_o", exp_a.size, m_ar_size_o);
          compare_value("m_ar_burst_o", exp_a.burst, m_ar_burst_o);
          compare_value("m_ar_id_o", exp_a.id, m_ar_id_o);
        end
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (exp_r.size() == 0) begin
          other_count++;
          $display("ERROR: upstream R beat at %0t with no beat expected", $time);
        end else begin
          exp_b = exp_r.pop_front();
          compare_value("s_r_data_o", exp_b.data, s_r_data_o);
          compare_value("s_r_id_o", exp_b.id, s_r_id_o);
          compare_value("s_r_last_o", exp_b.last, s_r_last_o);
          compare_value("s_r_resp_o", exp_b.resp, s_r_resp_o);
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    other_count++;
    $display("ERROR: timeout after %0d cycles with transfers still outstanding", cycle_count);
    finish_run();
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin : stimulus
    ar_t  up;
    len_t limit;
    int   p;
    int   b;
    rst_n_i      = 1'b0;
    len_limit_i  = '0;
    s_ar_valid_i = 1'b0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = BURST_INCR;
    s_ar_id_i    = '0;
    s_r_ready_i  = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    m_r_id_i     = '0;
    m_r_last_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    for (p = 0; p < PHASES; p++) begin
      // Phase 0 runs with limit zero and the rest pick 0 to 3
      limit       = (p == 0) ? len_t'(0) : len_t'(take_bits(2));
      len_limit_i = limit;
      for (b = 0; b < BURSTS; b++) begin
        up.addr  = addr_t'(take_bits(16)) << 4;
        up.len   = len_t'(take_bits(5) % 21);
        up.size  = size_t'(take_bits(2) % 3);
        up.burst = take_bit() ? BURST_INCR : BURST_FIXED;
        up.id    = id_t'(take_bits(4));
        build_expected(up, limit);
        send_burst(up);
      end
      // Drain all beats before the limit moves
      while (exp_r.size() != 0) begin
        @(posedge clk_i);
        #10;
      end
      @(posedge clk_i);
      #10;
    end
    if (exp_ar.size() != 0 || mem_ar.size() != 0) begin
      other_count++;
      $display("ERROR: sub-bursts left over after all beats returned");
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- burst_split_assert.sv
// Concurrent port checks for the burst splitter, attached to the top level through bind
`default_nettype none

module burst_split_assert
  import burst_split_pkg::*;
(
  input logic   clk_i,
  input logic   rst_n_i,
  input len_t   len_limit_i,
  input logic   s_ar_ready_o,
  input logic   s_r_valid_o,
  input logic   s_r_ready_i,
  input data_t  s_r_data_o,
  input resp_t  s_r_resp_o,
  input id_t    s_r_id_o,
  input logic   s_r_last_o,
  input logic   m_ar_valid_o,
  input logic   m_ar_ready_i,
  input addr_t  m_ar_addr_o,
  input len_t   m_ar_len_o,
  input size_t  m_ar_size_o,
  input burst_t m_ar_burst_o,
  input id_t    m_ar_id_o
);

  timeunit 1ns;
  timeprecision 1ns;

  // Failed assertions, read back by the testbench
  int unsigned fail_count = 0;

  // ----------------------------------------------------------------------
  // Sub-burst length
  // ----------------------------------------------------------------------
  a_len_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_ar_valid_o |-> (m_ar_len_o <= len_limit_i))
    else begin
      $error("m_ar_len_o above len_limit_i");
      fail_count++;
    end

  // ----------------------------------------------------------------------
  // Valid and payload held under back-pressure
  // ----------------------------------------------------------------------
  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_ar_valid_o && !m_ar_ready_i) |=> (m_ar_valid_o &&
      $stable({m_ar_addr_o, m_ar_len_o, m_ar_size_o, m_ar_burst_o, m_ar_id_o})))
    else begin
      $error("m_ar valid or payload changed while stalled");
      fail_count++;
    end

  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_r_valid_o && !s_r_ready_i) |=> (s_r_valid_o &&
      $stable({s_r_data_o, s_r_resp_o, s_r_id_o, s_r_last_o})))
    else begin
      $error("s_r valid or payload changed while stalled");
      fail_count++;
    end

  // Quiet upstream handshakes in reset
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> (!s_ar_ready_o && !s_r_valid_o))
    else begin
      $error("s_ar_ready_o or s_r_valid_o high during reset");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- burst_split_top.sv
// Top level of the read-only AXI4 burst splitter with plain AR and R ports on both sides
`default_nettype none

module burst_split_top
  import burst_split_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  // Max sub-burst length, as an AXI len
  input  len_t   len_limit_i,
  // ----------------------------------------------------------------------
  // Upstream port
  // ----------------------------------------------------------------------
  input  logic   s_ar_valid_i,
  output logic   s_ar_ready_o,
  input  addr_t  s_ar_addr_i,
  input  len_t   s_ar_len_i,
  input  size_t  s_ar_size_i,
  input  burst_t s_ar_burst_i,
  input  id_t    s_ar_id_i,
  output logic   s_r_valid_o,
  input  logic   s_r_ready_i,
  output data_t  s_r_data_o,
  output resp_t  s_r_resp_o,
  output id_t    s_r_id_o,
  output logic   s_r_last_o,
  // ----------------------------------------------------------------------
  // Downstream port
  // ----------------------------------------------------------------------
  output logic   m_ar_valid_o,
  input  logic   m_ar_ready_i,
  output addr_t  m_ar_addr_o,
  output len_t   m_ar_len_o,
  output size_t  m_ar_size_o,
  output burst_t m_ar_burst_o,
  output id_t    m_ar_id_o,
  input  logic   m_r_valid_i,
  output logic   m_r_ready_o,
  input  data_t  m_r_data_i,
  input  resp_t  m_r_resp_i,
  input  id_t    m_r_id_i,
  input  logic   m_r_last_i
);

  // Shared by allocator, table and R consumer
  beat_count_if u_cnt_if ();

  ar_split_fsm u_ar_split (
    .clk_i, .rst_n_i, .len_limit_i,
    .s_ar_valid_i, .s_ar_ready_o, .s_ar_addr_i, .s_ar_len_i,
    .s_ar_size_i, .s_ar_burst_i, .s_ar_id_i,
    .m_ar_valid_o, .m_ar_ready_i, .m_ar_addr_o, .m_ar_len_o,
    .m_ar_size_o, .m_ar_burst_o, .m_ar_id_o,
    .cnt_if (u_cnt_if.alloc)
  );

  beat_count_table u_count (
    .clk_i, .rst_n_i, .len_limit_i,
    .cnt_if (u_cnt_if.tbl)
  );

  r_last_rebuild u_r_last (
    .clk_i, .rst_n_i,
    .m_r_valid_i, .m_r_ready_o, .m_r_data_i, .m_r_resp_i, .m_r_id_i, .m_r_last_i,
    .s_r_valid_o, .s_r_ready_i, .s_r_data_o, .s_r_resp_o, .s_r_id_o, .s_r_last_o,
    .cnt_if (u_cnt_if.consume)
  );

endmodule

`default_nettype wire

//--- r_last_rebuild.sv
// R channel pass-through that rebuilds upstream last from the beat-count table head
`default_nettype none

module r_last_rebuild
  import burst_split_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Downstream R
  input  logic  m_r_valid_i,
  output logic  m_r_ready_o,
  input  data_t m_r_data_i,
  input  resp_t m_r_resp_i,
  input  id_t   m_r_id_i,
  input  logic  m_r_last_i,
  // Upstream R
  output logic  s_r_valid_o,
  input  logic  s_r_ready_i,
  output data_t s_r_data_o,
  output resp_t s_r_resp_o,
  output id_t   s_r_id_o,
  output logic  s_r_last_o,
  // Beat-count table head
  beat_count_if.consume cnt_if
);

  r_state_e state_q, state_d;
  // Last computed for a beat stuck upstream
  logic     last_q, last_d;

  // Payload is untouched
  assign s_r_data_o = m_r_data_i;
  assign s_r_resp_o = m_r_resp_i;
  assign s_r_id_o   = m_r_id_i;

  always_comb begin
    state_d             = state_q;
    last_d              = last_q;
    s_r_valid_o         = 1'b0;
    s_r_last_o          = 1'b0;
    m_r_ready_o         = 1'b0;
    cnt_if.head_consume = 1'b0;
    case (state_q)
      FEED: begin
        // Sub-burst end waits for a valid table head
        if (m_r_valid_i && (!m_r_last_i || cnt_if.head_valid)) begin
          s_r_valid_o = 1'b1;
          s_r_last_o  = m_r_last_i && cnt_if.head_final;
          last_d      = s_r_last_o;
          // Table is updated once per downstream last
          cnt_if.head_consume = m_r_last_i;
          if (s_r_ready_i) begin
            m_r_ready_o = 1'b1;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        // Downstream keeps the beat until we take it
        s_r_valid_o = m_r_valid_i;
        s_r_last_o  = last_q;
        if (m_r_valid_i && s_r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = FEED;
        end
      end
      default: state_d = FEED;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= FEED;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    last_q <= last_d;
  end

endmodule

`default_nettype wire

//--- beat_count_table.sv
// In-order table of remaining beats per outstanding burst, tells the R side which last is final
`default_nettype none

`include "burst_split_settings.svh"

module beat_count_table
  import burst_split_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  len_t len_limit_i,
  beat_count_if.tbl cnt_if
);

  localparam int unsigned DEPTH = `MAX_TXNS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  localparam cnt_t FULL_CNT = cnt_t'(DEPTH);

  beats_t mem_q [DEPTH];
  ptr_t   wr_ptr_q, rd_ptr_q;
  cnt_t   count_q;
  beats_t max_beats;
  beats_t head_beats;
  logic   alloc_fire;
  logic   pop;

  // Circular pointer step for any depth
  function automatic ptr_t ptr_next(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign max_beats  = beats_t'(len_limit_i) + beats_t'(1);
  assign head_beats = mem_q[rd_ptr_q];

  assign cnt_if.alloc_ready = (count_q != FULL_CNT);
  assign cnt_if.head_valid  = (count_q != '0);
  // One sub-burst or less left in the head entry
  assign cnt_if.head_final  = cnt_if.head_valid && (head_beats <= max_beats);

  assign alloc_fire = cnt_if.alloc_valid && cnt_if.alloc_ready;
  assign pop        = cnt_if.head_consume && cnt_if.head_final;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (alloc_fire) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({alloc_fire, pop})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  // Write and head slots differ whenever both fire, the table is then neither empty nor full
  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      mem_q[wr_ptr_q] <= cnt_if.alloc_beats;
    end
    if (cnt_if.head_consume && !cnt_if.head_final) begin
      mem_q[rd_ptr_q] <= head_beats - max_beats;
    end
  end

endmodule

`default_nettype wire

//--- ar_split_fsm.sv
// AR channel FSM that forwards short bursts and cuts long ones into sub-bursts downstream
`default_nettype none

module ar_split_fsm
  import burst_split_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  len_t   len_limit_i,
  // Upstream AR
  input  logic   s_ar_valid_i,
  output logic   s_ar_ready_o,
  input  addr_t  s_ar_addr_i,
  input  len_t   s_ar_len_i,
  input  size_t  s_ar_size_i,
  input  burst_t s_ar_burst_i,
  input  id_t    s_ar_id_i,
  // Downstream AR
  output logic   m_ar_valid_o,
  input  logic   m_ar_ready_i,
  output addr_t  m_ar_addr_o,
  output len_t   m_ar_len_o,
  output size_t  m_ar_size_o,
  output burst_t m_ar_burst_o,
  output id_t    m_ar_id_o,
  // Beat-count table allocation
  beat_count_if.alloc cnt_if
);

  ar_state_e state_q, state_d;
  // Stored long burst
  addr_t     addr_q, addr_d;
  beats_t    remain_q, remain_d;
  size_t     size_q;
  burst_t    burst_q;
  id_t       id_q;
  logic      load;
  // Beats per full sub-burst
  beats_t    max_beats;
  logic      fits;
  logic      sub_final;

  assign max_beats = beats_t'(len_limit_i) + beats_t'(1);
  assign fits      = (s_ar_len_i <= len_limit_i);
  // Remainder is the last sub-burst
  assign sub_final = (remain_q <= max_beats);

  assign cnt_if.alloc_beats = beats_t'(s_ar_len_i) + beats_t'(1);

  // ----------------------------------------------------------------------
  // Next state and outputs
  // ----------------------------------------------------------------------
  always_comb begin
    state_d            = state_q;
    addr_d             = addr_q;
    remain_d           = remain_q;
    load               = 1'b0;
    s_ar_ready_o       = 1'b0;
    m_ar_valid_o       = 1'b0;
    cnt_if.alloc_valid = 1'b0;
    // Payload follows upstream by default
    m_ar_addr_o        = s_ar_addr_i;
    m_ar_len_o         = s_ar_len_i;
    m_ar_size_o        = s_ar_size_i;
    m_ar_burst_o       = s_ar_burst_i;
    m_ar_id_o          = s_ar_id_i;
    case (state_q)
      IDLE: begin
        // Nothing moves without a free table entry
        if (s_ar_valid_i && cnt_if.alloc_ready) begin
          if (fits) begin
            // Pass through, allocate on downstream accept
            m_ar_valid_o = 1'b1;
            if (m_ar_ready_i) begin
              cnt_if.alloc_valid = 1'b1;
              s_ar_ready_o       = 1'b1;
            end
          end else begin
            // Take the burst now, split from next cycle on
            cnt_if.alloc_valid = 1'b1;
            s_ar_ready_o       = 1'b1;
            load               = 1'b1;
            addr_d             = s_ar_addr_i;
            remain_d           = cnt_if.alloc_beats;
            state_d            = BUSY;
          end
        end
      end
      BUSY: begin
        m_ar_valid_o = 1'b1;
        m_ar_addr_o  = addr_q;
        m_ar_len_o   = sub_final ? len_t'(remain_q - beats_t'(1)) : len_limit_i;
        m_ar_size_o  = size_q;
        m_ar_burst_o = burst_q;
        m_ar_id_o    = id_q;
        if (m_ar_ready_i) begin
          if (sub_final) begin
            state_d = IDLE;
          end else begin
            remain_d = remain_q - max_beats;
            // FIXED bursts keep their address
            if (burst_q == BURST_INCR) begin
              addr_d = addr_q + (addr_t'(max_beats) << size_q);
            end
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q   <= addr_d;
    remain_q <= remain_d;
    if (load) begin
      size_q  <= s_ar_size_i;
      burst_q <= s_ar_burst_i;
      id_q    <= s_ar_id_i;
    end
  end

endmodule

`default_nettype wire

//--- beat_count_if.sv
// Link between the beat-count table, the AR splitter that fills it and the R side that drains it
`default_nettype none

interface beat_count_if
  import burst_split_pkg::*;
();

  // Allocation of one original burst
  logic   alloc_valid;
  logic   alloc_ready;
  // Total beats of the burst, len + 1
  beats_t alloc_beats;

  // Oldest outstanding burst
  logic   head_valid;
  // High when the next downstream last ends the original burst
  logic   head_final;
  // One sub-burst of the head entry has completed
  logic   head_consume;

  // AR splitter side
  modport alloc   (output alloc_valid, output alloc_beats, input alloc_ready);

  // Table side
  modport tbl     (input  alloc_valid, input  alloc_beats, output alloc_ready,
                   output head_valid,  output head_final,  input  head_consume);

  // R side
  modport consume (input head_valid, input head_final, output head_consume);

endinterface

`default_nettype wire

//--- burst_split_pkg.sv
// Shared types of the burst splitter, imported by every RTL module that needs them
`default_nettype none

`include "burst_split_settings.svh"

package burst_split_pkg;

  // Plain vectors for AXI fields
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`ID_W-1:0]   id_t;
  typedef logic [`LEN_W-1:0]  len_t;
  // One bit wider than len_t so a full 256-beat burst fits
  typedef logic [`LEN_W:0]    beats_t;
  typedef logic [2:0]         size_t;
  typedef logic [1:0]         burst_t;
  typedef logic [1:0]         resp_t;

  // Burst codes in use, WRAP is not handled
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  // AR splitter states
  typedef enum logic {IDLE, BUSY} ar_state_e;

  // R last rebuild states
  typedef enum logic {FEED, HOLD} r_state_e;

endpackage

`default_nettype wire

//--- burst_split_settings.svh
// Global widths and table depth for the AXI read burst splitter, include where needed
`ifndef BURST_SPLIT_SETTINGS_SVH
`define BURST_SPLIT_SETTINGS_SVH

// ----------------------------------------------------------------------
// AXI channel widths
// ----------------------------------------------------------------------
// Byte address
`define ADDR_W 32
// Read data bus
`define DATA_W 32
// Transaction ID
`define ID_W 4
// AXI4 length field, beats minus one
`define LEN_W 8

// ----------------------------------------------------------------------
// Splitter sizing
// ----------------------------------------------------------------------
// Outstanding original bursts tracked by the beat-count table
`define MAX_TXNS 4

`endif
